/* all.f */
+incdir+verification
common/wb_pkg.sv
verilog/wb_interconnect.sv
wb_sram/wb_sram.sv
wb_timer/wb_timer.sv
verilog/wb_subsystem_top.sv
verification/tb_wb_subsystem.sv

/* common/wb_pkg.sv */
// shared wishbone types, bus bundles, slave codes and register map, imported by every rtl block
package wb_pkg;

    // byte address, top byte selects the slave
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    // one enable per byte lane
    typedef logic [3:0]  wb_sel_t;
    typedef logic [7:0]  slave_id_t;
    // bit n set when slave n interrupts
    typedef logic [31:0] irq_vec_t;

    // master to slave, 71 bits
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_sel_t  sel;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // slave to master, 34 bits
    typedef struct packed {
        logic     ack;
        logic     irq;
        wb_data_t dat;
    } wb_rsp_t;

    // slave codes in adr[31:24]
    localparam slave_id_t SLV_SRAM  = 8'h00;
    localparam slave_id_t SLV_TIMER = 8'h01;

    // scratch memory depth and word index width
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_AW    = $clog2(SRAM_WORDS);

    // timer register offsets, low nibble of the offset
    localparam logic [3:0] TMR_CTRL   = 4'h0;
    localparam logic [3:0] TMR_LOAD   = 4'h4;
    localparam logic [3:0] TMR_COUNT  = 4'h8;
    localparam logic [3:0] TMR_STATUS = 4'hC;

    // ctrl register bits
    localparam int CTRL_EN     = 0;
    localparam int CTRL_IRQ_EN = 1;
    localparam int CTRL_RELOAD = 2;

    typedef enum logic {
        T_IDLE,
        T_RUN
    } timer_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the wishbone subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 \
    --top-module tb_wb_subsystem \
    -Mdir obj_dir \
    -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_wb_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

/* verification/tb_wb_tasks.svh */
// bus access tasks, xorshift generator and sram shadow model, included inside the testbench module
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

    // sram shadow, per-lane written flags
    wb_data_t shadow_mem [SRAM_WORDS];
    wb_sel_t  shadow_ok  [SRAM_WORDS];
    logic [31:0] rng_state = 32'hd4fa;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic wb_addr_t tmr_adr(input logic [3:0] off);
        return {SLV_TIMER, 20'd0, off};
    endfunction

    // one classic cycle, request held until ack
    task automatic bus_access(input wb_addr_t adr, input logic we, input wb_sel_t sel,
                              input wb_data_t wdat, output wb_data_t rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        m_req.cyc = 1'b1;
        m_req.stb = 1'b1;
        m_req.we  = we;
        m_req.sel = sel;
        m_req.adr = adr;
        m_req.dat = wdat;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 16) begin
                $display("no ack on the bus after 16 cycles, address %h", adr);
                fail_stop();
            end
        end while (!m_rsp.ack);
        rdat = m_rsp.dat;
        // hold through the edge that samples ack, then release the bus
        @(posedge clk);
        #1;
        m_req = '0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel);
        wb_data_t unused;
        bus_access(adr, 1'b1, sel, dat, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        bus_access(adr, 1'b0, 4'h0, '0, dat);
    endtask

    // keep the shadow in step with a lane write
    task automatic shadow_write(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel);
        int w;
        w = int'(adr[SRAM_AW+1:2]);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                shadow_mem[w][8*b +: 8] = dat[8*b +: 8];
                shadow_ok[w][b] = 1'b1;
            end
        end
    endtask

    // compare only lanes that were ever written
    task automatic sram_check(input wb_addr_t adr);
        wb_data_t rd;
        wb_data_t mask;
        int w;
        w = int'(adr[SRAM_AW+1:2]);
        wb_read(adr, rd);
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{shadow_ok[w][b]}};
        end
        check_value("m_rsp_o.dat (sram)", shadow_mem[w] & mask, rd & mask);
    endtask

`endif

/* verification/tb_wb_subsystem.sv */
// testbench for the wishbone subsystem, drives the master port and checks through assertions
`timescale 1ns/1ps

module tb_wb_subsystem;
    import wb_pkg::*;

    localparam int N_ONESHOT    = 10;
    localparam int M_RELOAD     = 8;
    localparam int N_RAND       = 24;
    // bus accesses scheduled by the stimulus below
    localparam int NUM_ACCESSES = 2 * N_RAND + 35;
    // slack in the per-access budget covers the timer waits
    localparam int WATCHDOG_NS  = 200 + 40 * NUM_ACCESSES;

    logic    clk;
    logic    rst_i;
    wb_req_t m_req;
    wb_rsp_t m_rsp;
    int      cycle_cnt;
    wb_addr_t touched [$];

    wb_subsystem_top wb_subsystem_top_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .m_req_i (m_req),
        .m_rsp_o (m_rsp)
    );

    task automatic fail_stop();
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input wb_data_t exp, input wb_data_t act);
        assert (act === exp)
        else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            fail_stop();
        end
    endtask

    `include "tb_wb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run took longer than %0d ns", WATCHDOG_NS);
        fail_stop();
    end

    // ack exactly one cycle after stb rises
    a_ack_after_stb: assert property (
        @(posedge clk) disable iff (rst_i)
        $rose(m_req.stb) |=> m_rsp.ack
    ) else begin
        $display("ack did not follow stb by exactly one cycle");
        fail_stop();
    end

    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst_i)
        m_rsp.ack |=> !m_rsp.ack
    ) else begin
        $display("ack stayed high for more than one cycle");
        fail_stop();
    end

    // no ack without a request the cycle before
    a_ack_needs_stb: assert property (
        @(posedge clk) disable iff (rst_i)
        m_rsp.ack |-> $past(m_req.stb)
    ) else begin
        $display("ack appeared without a strobe");
        fail_stop();
    end

    // poll irq until it rises or the limit runs out
    task automatic wait_irq(input int limit);
        int n;
        n = 0;
        while (!m_rsp.irq) begin
            @(posedge clk);
            #1;
            n++;
            if (n > limit) begin
                $display("timer interrupt did not rise within %0d cycles", limit);
                fail_stop();
            end
        end
    endtask

    initial begin
        wb_data_t rd;
        wb_addr_t adr;
        wb_data_t dat;
        wb_sel_t  sel;
        int       last_exp;
        m_req     = '0;
        rst_i     = 1'b1;
        cycle_cnt = 0;
        for (int i = 0; i < SRAM_WORDS; i++) begin
            shadow_ok[i] = 4'h0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // reset state, one access per target
        check_value("m_rsp_o.ack", 32'd0, {31'd0, m_rsp.ack});
        check_value("m_rsp_o.irq", 32'd0, {31'd0, m_rsp.irq});
        wb_write(32'h0000_0100, 32'hcafe_f00d, 4'hF);
        shadow_write(32'h0000_0100, 32'hcafe_f00d, 4'hF);
        touched.push_back(32'h0000_0100);
        wb_read(tmr_adr(TMR_COUNT), rd);
        check_value("timer COUNT", 32'd0, rd);
        wb_read(32'h7F00_0000, rd);
        check_value("irq vector", 32'd0, rd);

        // random sram traffic, random upper bits exercise aliasing
        for (int i = 0; i < N_RAND; i++) begin
            rng_state = xorshift(rng_state);
            adr = {SLV_SRAM, rng_state[23:2], 2'b00};
            rng_state = xorshift(rng_state);
            dat = rng_state;
            rng_state = xorshift(rng_state);
            sel = (rng_state[3:0] == 4'h0) ? 4'hF : rng_state[3:0];
            wb_write(adr, dat, sel);
            shadow_write(adr, dat, sel);
            touched.push_back(adr);
        end
        // read back with fresh offset bits above 9, same word
        foreach (touched[i]) begin
            rng_state = xorshift(rng_state);
            sram_check({SLV_SRAM, rng_state[13:0], touched[i][9:0]});
        end
        sram_check(touched[0] | 32'h00FF_FC00);

        // decode isolation, sram writes at timer offsets
        wb_write(tmr_adr(TMR_LOAD), N_ONESHOT, 4'hF);
        wb_write(tmr_adr(TMR_CTRL), 32'h2, 4'hF);
        for (int off = 0; off < 16; off += 4) begin
            adr = {SLV_SRAM, 24'(off)};
            wb_write(adr, 32'h5a5a_0000 + off, 4'hF);
            shadow_write(adr, 32'h5a5a_0000 + off, 4'hF);
            touched.push_back(adr);
        end
        wb_read(tmr_adr(TMR_LOAD), rd);
        check_value("timer LOAD", N_ONESHOT, rd);
        wb_read(tmr_adr(TMR_CTRL), rd);
        check_value("timer CTRL", 32'h2, rd);

        // one-shot, irq exactly N cycles after the ctrl ack
        wb_write(tmr_adr(TMR_CTRL), 32'h3, 4'hF);
        // the ack edge lies one cycle before the write returns
        check_value("m_rsp_o.irq", 32'd0, {31'd0, m_rsp.irq});
        for (int i = 2; i < N_ONESHOT; i++) begin
            @(posedge clk);
            #1;
            check_value("m_rsp_o.irq", 32'd0, {31'd0, m_rsp.irq});
        end
        @(posedge clk);
        #1;
        check_value("m_rsp_o.irq", 32'd1, {31'd0, m_rsp.irq});
        wb_read(tmr_adr(TMR_STATUS), rd);
        check_value("timer STATUS", 32'd1, rd);
        wb_read(tmr_adr(TMR_COUNT), rd);
        check_value("timer COUNT", 32'd0, rd);
        for (int i = 0; i < N_ONESHOT; i++) begin
            @(posedge clk);
            #1;
            check_value("m_rsp_o.irq", 32'd1, {31'd0, m_rsp.irq});
        end
        wb_read(tmr_adr(TMR_COUNT), rd);
        check_value("timer COUNT", 32'd0, rd);

        // vector through the default slave, then clear
        wb_read(32'h7F00_0000, rd);
        check_value("irq vector", 32'h2, rd);
        wb_write(tmr_adr(TMR_STATUS), 32'h1, 4'hF);
        check_value("m_rsp_o.irq", 32'd0, {31'd0, m_rsp.irq});
        wb_read(32'h7F00_0000, rd);
        check_value("irq vector", 32'h0, rd);

        // irq masked, pending still latches
        wb_write(tmr_adr(TMR_CTRL), 32'h1, 4'hF);
        for (int i = 0; i < N_ONESHOT + 2; i++) begin
            @(posedge clk);
            #1;
            check_value("m_rsp_o.irq", 32'd0, {31'd0, m_rsp.irq});
        end
        wb_read(tmr_adr(TMR_STATUS), rd);
        check_value("timer STATUS", 32'd1, rd);
        wb_write(tmr_adr(TMR_STATUS), 32'h1, 4'hF);

        // auto-reload, each expiry within M cycles of the last
        wb_write(tmr_adr(TMR_LOAD), M_RELOAD, 4'hF);
        wb_write(tmr_adr(TMR_CTRL), 32'h7, 4'hF);
        wait_irq(M_RELOAD + 2);
        last_exp = cycle_cnt;
        for (int k = 0; k < 3; k++) begin
            wb_write(tmr_adr(TMR_STATUS), 32'h1, 4'hF);
            check_value("m_rsp_o.irq", 32'd0, {31'd0, m_rsp.irq});
            wait_irq(M_RELOAD);
            assert (cycle_cnt - last_exp <= M_RELOAD)
            else begin
                $display("reload expiry came %0d cycles after the previous one",
                         cycle_cnt - last_exp);
                fail_stop();
            end
            last_exp = cycle_cnt;
        end
        wb_write(tmr_adr(TMR_CTRL), 32'h0, 4'hF);
        wb_write(tmr_adr(TMR_STATUS), 32'h1, 4'hF);

        // timer traffic must not have touched the sram
        for (int i = touched.size() - 4; i < touched.size(); i++) begin
            sram_check(touched[i]);
        end
        sram_check(touched[0]);

        $display("** PASS **");
        $finish;
    end

endmodule

/* verilog/wb_interconnect.sv */
// one-master two-slave wishbone decoder, routes requests by address byte and answers unmapped codes
`timescale 1ns/1ps

module wb_interconnect (
    input  logic            clk,
    input  logic            rst_i,
    // master side
    input  wb_pkg::wb_req_t m_req_i,
    output wb_pkg::wb_rsp_t m_rsp_o,
    // slave 0, scratch sram
    output wb_pkg::wb_req_t s0_req_o,
    input  wb_pkg::wb_rsp_t s0_rsp_i,
    // slave 1, timer
    output wb_pkg::wb_req_t s1_req_o,
    input  wb_pkg::wb_rsp_t s1_rsp_i
);
    import wb_pkg::*;

    slave_id_t slave_code;
    logic      hit_sram;
    logic      hit_timer;
    logic      hit_none;
    wb_req_t   fwd_req;
    irq_vec_t  irq_vec;
    logic      dflt_ack;

    // decode on the top address byte
    assign slave_code = m_req_i.adr[31:24];
    assign hit_sram   = (slave_code == SLV_SRAM);
    assign hit_timer  = (slave_code == SLV_TIMER);
    assign hit_none   = ~hit_sram & ~hit_timer;

    // slaves see only the offset
    always_comb begin
        fwd_req            = m_req_i;
        fwd_req.adr[31:24] = '0;
    end

    // unaddressed slave gets an idle all-zero bus
    assign s0_req_o = hit_sram  ? fwd_req : '0;
    assign s1_req_o = hit_timer ? fwd_req : '0;

    // interrupt vector, one bit per slave
    always_comb begin
        irq_vec    = '0;
        irq_vec[0] = s0_rsp_i.irq;
        irq_vec[1] = s1_rsp_i.irq;
    end

    // default slave for unmapped codes
    // same single-cycle ack rule as the real slaves
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dflt_ack <= 1'b0;
        end else begin
            dflt_ack <= hit_none & m_req_i.cyc & m_req_i.stb & ~dflt_ack;
        end
    end

    // response mux back to the master
    always_comb begin
        m_rsp_o.irq = |irq_vec;
        if (hit_sram) begin
            m_rsp_o.ack = s0_rsp_i.ack;
            m_rsp_o.dat = s0_rsp_i.dat;
        end else if (hit_timer) begin
            m_rsp_o.ack = s1_rsp_i.ack;
            m_rsp_o.dat = s1_rsp_i.dat;
        end else begin
            // stray access reads back who is interrupting
            m_rsp_o.ack = dflt_ack;
            m_rsp_o.dat = irq_vec;
        end
    end

    // at most one slave is ever strobed
    a_one_strobe: assert property (
        @(posedge clk) disable iff (rst_i)
        !(s0_req_o.stb && s1_req_o.stb)
    );

    // the slaves' acks only answer a cycle the master still holds open
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (rst_i)
        m_rsp_o.ack |-> m_req_i.cyc
    );

endmodule

/* verilog/wb_subsystem_top.sv */
// wishbone subsystem top, one master port feeding the decoder with sram and timer behind it
`timescale 1ns/1ps

module wb_subsystem_top (
    input  logic            clk,
    input  logic            rst_i,
    // master port
    input  wb_pkg::wb_req_t m_req_i,
    output wb_pkg::wb_rsp_t m_rsp_o
);
    import wb_pkg::*;

    // decoder to sram
    wb_req_t sram_req;
    wb_rsp_t sram_rsp;
    // decoder to timer
    wb_req_t timer_req;
    wb_rsp_t timer_rsp;

    wb_interconnect wb_interconnect_i (
        .clk      (clk),
        .rst_i    (rst_i),
        .m_req_i  (m_req_i),
        .m_rsp_o  (m_rsp_o),
        .s0_req_o (sram_req),
        .s0_rsp_i (sram_rsp),
        .s1_req_o (timer_req),
        .s1_rsp_i (timer_rsp)
    );

    // slave 0
    wb_sram wb_sram_i (
        .clk   (clk),
        .rst_i (rst_i),
        .req_i (sram_req),
        .rsp_o (sram_rsp)
    );

    // slave 1
    wb_timer wb_timer_i (
        .clk   (clk),
        .rst_i (rst_i),
        .req_i (timer_req),
        .rsp_o (timer_rsp)
    );

endmodule

/* wb_sram/wb_sram.sv */
// word-addressed scratch memory slave with byte-lane writes, sits on slave code 0
`timescale 1ns/1ps

module wb_sram (
    input  logic            clk,
    input  logic            rst_i,
    input  wb_pkg::wb_req_t req_i,
    output wb_pkg::wb_rsp_t rsp_o
);
    import wb_pkg::*;

    wb_data_t           mem [SRAM_WORDS];
    logic [SRAM_AW-1:0] word_idx;
    logic               access;
    logic               ack_q;
    wb_data_t           rd_q;

    // new access only when not already acking
    assign access   = req_i.cyc & req_i.stb & ~ack_q;
    // bits above 9 alias onto the same word
    assign word_idx = req_i.adr[SRAM_AW+1:2];

    // ack one cycle after stb seen, never back to back
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // storage and read register
    always_ff @(posedge clk) begin
        if (access) begin
            // read data lines up with ack
            rd_q <= mem[word_idx];
            if (req_i.we) begin
                // only enabled lanes change
                for (int b = 0; b < $bits(wb_sel_t); b++) begin
                    if (req_i.sel[b]) begin
                        mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        rsp_o.ack = ack_q;
        // memory never interrupts
        rsp_o.irq = 1'b0;
        rsp_o.dat = rd_q;
    end

    // single-cycle ack per access
    a_ack_single: assert property (
        @(posedge clk) disable iff (rst_i)
        ack_q |=> !ack_q
    );

endmodule

/* wb_timer/wb_timer.sv */
// down-counting timer slave with one-shot or auto-reload and a sticky interrupt, slave code 1
`timescale 1ns/1ps

module wb_timer (
    input  logic            clk,
    input  logic            rst_i,
    input  wb_pkg::wb_req_t req_i,
    output wb_pkg::wb_rsp_t rsp_o
);
    import wb_pkg::*;

    timer_state_t state;
    timer_state_t state_nxt;
    logic [2:0]   ctrl;
    wb_data_t     load;
    wb_data_t     count;
    wb_data_t     count_nxt;
    logic         pending;
    logic         expire;
    logic         access;
    logic         wr_en;
    logic [3:0]   reg_off;
    logic         ack_q;
    wb_data_t     rd_q;

    // same handshake as the sram
    assign access  = req_i.cyc & req_i.stb & ~ack_q;
    assign wr_en   = access & req_i.we;
    // register select, upper offset bits alias
    assign reg_off = req_i.adr[3:0];

    // free-running count step, bus writes override below
    always_comb begin
        state_nxt = state;
        count_nxt = count;
        expire    = 1'b0;
        if (state == T_RUN) begin
            if (count <= 32'd1) begin
                // reaching zero, also covers a zero load
                expire = 1'b1;
                if (ctrl[CTRL_RELOAD]) begin
                    count_nxt = load;
                end else begin
                    count_nxt = '0;
                    state_nxt = T_IDLE;
                end
            end else begin
                count_nxt = count - 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state   <= T_IDLE;
            ctrl    <= '0;
            load    <= '0;
            count   <= '0;
            pending <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            state <= state_nxt;
            count <= count_nxt;
            if (expire) begin
                pending <= 1'b1;
            end
            // register writes land on the ack edge
            if (wr_en) begin
                case (reg_off)
                    TMR_CTRL: begin
                        ctrl <= req_i.dat[2:0];
                        if (req_i.dat[CTRL_EN]) begin
                            // start from the programmed load
                            count <= load;
                            state <= T_RUN;
                        end else begin
                            state <= T_IDLE;
                        end
                    end
                    TMR_LOAD: begin
                        load <= req_i.dat;
                        // a smaller load pulls a running count down
                        if (state_nxt == T_RUN && count_nxt > req_i.dat) begin
                            count <= req_i.dat;
                        end
                    end
                    TMR_STATUS: begin
                        // write one to clear, a fresh expiry wins
                        if (req_i.dat[0] && !expire) begin
                            pending <= 1'b0;
                        end
                    end
                    default: begin
                        // count is read only
                    end
                endcase
            end
        end
    end

    // read register, captured with ack
    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_off)
                TMR_CTRL:   rd_q <= {29'd0, ctrl};
                TMR_LOAD:   rd_q <= load;
                TMR_COUNT:  rd_q <= count;
                TMR_STATUS: rd_q <= {31'd0, pending};
                default:    rd_q <= '0;
            endcase
        end
    end

    always_comb begin
        rsp_o.ack = ack_q;
        // pending is masked, not cleared, by irq enable
        rsp_o.irq = pending & ctrl[CTRL_IRQ_EN];
        rsp_o.dat = rd_q;
    end

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst_i)
        ack_q |=> !ack_q
    );

    // load changes and reloads keep the counter in range
    a_count_le_load: assert property (
        @(posedge clk) disable iff (rst_i)
        (state == T_RUN) |-> (count <= load)
    );

endmodule
